// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tbSudoku
FILELIST = compile.f
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== candidateCell.sv ====
`timescale 1ns/1ps

module candidateCell (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 start,
   input  sudokuPkg::cellMask_t startValue,
   input  sudokuPkg::cellMask_t peerSolved,
   output sudokuPkg::cellMask_t value,
   output logic                 done,
   output logic                 changed,
   output logic                 empty
);
   import sudokuPkg::*;

   cellMask_t pruned;
   cellMask_t nextValue;

   assign pruned = value & ~peerSolved;   // drop digits already taken by peers

   always_comb
   begin
      if (done)
      begin
         nextValue = value;   // solved cells hold
      end
      else
      begin
         nextValue = pruned;
      end
   end

   assign done    = isSingle(value);
   assign empty   = (value == '0);
   assign changed = (nextValue != value);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         value <= '0;
      end
      else if (start)
      begin
         value <= startValue;
      end
      else
      begin
         value <= nextValue;
      end
   end

   // once single, the cell keeps its digit until the next load
   doneHolds: assert property (
      @(posedge clk) disable iff (rst)
      done && !start |=> $stable(value)
   )
   else $error("solved cell changed without start");

endmodule

// ==== cellArray.sv ====
`timescale 1ns/1ps
`include "sudoku_params.svh"

module cellArray (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      start,
   input  sudokuPkg::grid_t          inGrid,
   output sudokuPkg::grid_t          grid,
   output logic [`SUDOKU_CELLS-1:0]  cellDone,
   output logic [`SUDOKU_CELLS-1:0]  cellChanged,
   output logic [`SUDOKU_CELLS-1:0]  cellEmpty
);
   import sudokuPkg::*;

   // mask of a peer if it is solved and is not the cell itself
   function automatic cellMask_t peerBits(
      input int                     idx,
      input int                     self,
      input logic [`SUDOKU_CELLS-1:0] doneVec,
      input grid_t                  g
   );
      return (idx != self && doneVec[idx]) ? g[idx] : '0;
   endfunction

   for (genvar i = 0; i < `SUDOKU_CELLS; i++)
   begin : gCell
      localparam int Row    = i / `SUDOKU_DIM;
      localparam int Col    = i % `SUDOKU_DIM;
      localparam int BoxRow = Row - Row % `SUDOKU_BOX;   // top row of the box
      localparam int BoxCol = Col - Col % `SUDOKU_BOX;

      cellMask_t peerSolved;
      int        rowIdx;
      int        colIdx;
      int        boxIdx;

      always_comb
      begin
         peerSolved = '0;
         for (int k = 0; k < `SUDOKU_DIM; k++)
         begin
            rowIdx = Row * `SUDOKU_DIM + k;
            colIdx = k * `SUDOKU_DIM + Col;
            boxIdx = (BoxRow + k / `SUDOKU_BOX) * `SUDOKU_DIM + BoxCol + k % `SUDOKU_BOX;
            peerSolved = peerSolved | peerBits(rowIdx, i, cellDone, grid);
            peerSolved = peerSolved | peerBits(colIdx, i, cellDone, grid);
            peerSolved = peerSolved | peerBits(boxIdx, i, cellDone, grid);
         end
      end

      candidateCell uCell (
         .clk        (clk),
         .rst        (rst),
         .start      (start),
         .startValue (inGrid[i]),
         .peerSolved (peerSolved),
         .value      (grid[i]),
         .done       (cellDone[i]),
         .changed    (cellChanged[i]),
         .empty      (cellEmpty[i])
      );
   end

endmodule

// ==== compile.f ====
+incdir+.
sudokuPkg.sv
candidateCell.sv
cellArray.sv
groupChecker.sv
solveMonitor.sv
sudokuSolver.sv
sudokuChecker.sv
tbSudoku.sv

// ==== groupChecker.sv ====
`timescale 1ns/1ps
`include "sudoku_params.svh"

module groupChecker (
   input  sudokuPkg::grid_t grid,
   output logic             groupConflict
);
   import sudokuPkg::*;

   logic [3*`SUDOKU_DIM-1:0] groupBad;   // rows, then columns, then boxes

   function automatic logic hasDup(input cellMask_t [`SUDOKU_DIM-1:0] members);
      cellMask_t seen;
      logic      dup;
      seen = '0;
      dup  = 1'b0;
      for (int k = 0; k < `SUDOKU_DIM; k++)
      begin
         if (isSingle(members[k]))
         begin
            dup  = dup | (|(seen & members[k]));
            seen = seen | members[k];
         end
      end
      return dup;
   endfunction

   for (genvar g = 0; g < `SUDOKU_DIM; g++)
   begin : gGroup
      cellMask_t [`SUDOKU_DIM-1:0] rowCells;
      cellMask_t [`SUDOKU_DIM-1:0] colCells;
      cellMask_t [`SUDOKU_DIM-1:0] boxCells;

      for (genvar k = 0; k < `SUDOKU_DIM; k++)
      begin : gMember
         assign rowCells[k] = grid[g * `SUDOKU_DIM + k];
         assign colCells[k] = grid[k * `SUDOKU_DIM + g];
         assign boxCells[k] = grid[(g / `SUDOKU_BOX * `SUDOKU_BOX + k / `SUDOKU_BOX) * `SUDOKU_DIM
                                   + g % `SUDOKU_BOX * `SUDOKU_BOX + k % `SUDOKU_BOX];
      end

      assign groupBad[g]                 = hasDup(rowCells);
      assign groupBad[`SUDOKU_DIM + g]   = hasDup(colCells);
      assign groupBad[2*`SUDOKU_DIM + g] = hasDup(boxCells);
   end

   assign groupConflict = |groupBad;

endmodule

// ==== solveMonitor.sv ====
`timescale 1ns/1ps
`include "sudoku_params.svh"

module solveMonitor (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     start,
   input  logic [`SUDOKU_CELLS-1:0] cellDone,
   input  logic [`SUDOKU_CELLS-1:0] cellChanged,
   input  logic [`SUDOKU_CELLS-1:0] cellEmpty,
   input  logic                     groupConflict,
   output sudokuPkg::solveStatus_t  status
);
   import sudokuPkg::*;

   localparam int StallW = $clog2(`SUDOKU_STALL_LIMIT + 1);

   solveState_t       state;
   solveState_t       nextState;
   cellCount_t        notDoneCount;
   cellCount_t        unsolvedReg;
   logic [StallW-1:0] stallCount;
   logic              changedReg;
   logic              timeOut;
   logic              allDone;
   logic              anyError;

   assign allDone  = &cellDone;
   assign timeOut  = (stallCount == StallW'(`SUDOKU_STALL_LIMIT));
   assign anyError = ((|cellEmpty) || groupConflict) && (state != Idle);   // masked before first load

   always_comb
   begin
      notDoneCount = '0;
      for (int i = 0; i < `SUDOKU_CELLS; i++)
      begin
         if (!cellDone[i])
            notDoneCount = notDoneCount + 1'b1;
      end
   end

   always_comb
   begin
      nextState = state;
      if (start)
         nextState = Running;   // restart from any state
      else if (state == Running)
      begin
         if (allDone && !anyError)
            nextState = Solved;
         else if (timeOut || anyError)
            nextState = Stuck;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state       <= Idle;
         unsolvedReg <= cellCount_t'(`SUDOKU_CELLS);
         stallCount  <= '0;
         changedReg  <= 1'b0;
      end
      else
      begin
         state       <= nextState;
         unsolvedReg <= start ? cellCount_t'(`SUDOKU_CELLS) : notDoneCount;
         changedReg  <= |cellChanged;
         if (start || (|cellChanged))
            stallCount <= '0;
         else if (!timeOut)
            stallCount <= stallCount + 1'b1;   // saturates at the limit
      end
   end

   assign status = '{state: state, unsolvedCells: unsolvedReg, timeOut: timeOut,
                     allDone: allDone, anyChanged: changedReg, anyError: anyError};

   // a conflict-free full grid is stable, so Solved never meets an error
   solvedClean: assert property (
      @(posedge clk) disable iff (rst)
      state == Solved |-> !anyError
   )
   else $error("error flagged while solved");

endmodule

// ==== sudokuChecker.sv ====
`timescale 1ns/1ps
`include "sudoku_params.svh"

module sudokuChecker (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    start,
   input  sudokuPkg::grid_t        inGrid,
   input  sudokuPkg::grid_t        outGrid,
   input  sudokuPkg::solveStatus_t status,
   input  sudokuPkg::grid_t        expGrid,
   input  sudokuPkg::solveStatus_t expStatus,
   input  sudokuPkg::grid_t        solution,
   input  logic                    dupPlanted,
   output int                      gridErrors,
   output int                      statusErrors,
   output int                      endErrors
);
   import sudokuPkg::*;

   int    nGrid = 0;
   int    nStatus = 0;
   int    nEnd = 0;
   logic  loadSeen = 1'b0;
   grid_t loadGrid;

   assign gridErrors   = nGrid;
   assign statusErrors = nStatus;
   assign endErrors    = nEnd;

   // reports the first cell that differs
   function automatic logic gridDiffers(input string what, input grid_t got, input grid_t exp);
      for (int i = 0; i < `SUDOKU_CELLS; i++)
      begin
         if (got[i] != exp[i])
         begin
            $display("FAIL %s[%0d]: got %h expected %h", what, i, got[i], exp[i]);
            return 1'b1;
         end
      end
      return 1'b0;
   endfunction

   task automatic checkField(input string what, input int got, input int exp);
      if (got != exp)
      begin
         $display("FAIL status.%s: got %h expected %h", what, got, exp);
         nStatus++;
      end
   endtask

   always @(posedge clk)
   begin
      loadSeen <= start && !rst;
      loadGrid <= inGrid;
   end

   always @(negedge clk)
   begin
      if (!rst)
      begin
         if (loadSeen)   // first cycle after a load
         begin
            if (gridDiffers("outGrid(load)", outGrid, loadGrid))
               nGrid++;
            checkField("unsolvedCells(load)", int'(status.unsolvedCells), `SUDOKU_CELLS);
         end
         if (gridDiffers("outGrid", outGrid, expGrid))
            nGrid++;
         checkField("state", int'(status.state), int'(expStatus.state));
         checkField("unsolvedCells", int'(status.unsolvedCells), int'(expStatus.unsolvedCells));
         checkField("timeOut", int'(status.timeOut), int'(expStatus.timeOut));
         checkField("allDone", int'(status.allDone), int'(expStatus.allDone));
         checkField("anyChanged", int'(status.anyChanged), int'(expStatus.anyChanged));
         checkField("anyError", int'(status.anyError), int'(expStatus.anyError));
         if (status.state == Solved)
         begin
            if (gridDiffers("outGrid(solved)", outGrid, solution))
               nEnd++;
            if (dupPlanted)
            begin
               $display("puzzle with a planted duplicate reached the solved state");
               nEnd++;
            end
         end
      end
   end

endmodule

// ==== sudokuPkg.sv ====
`include "sudoku_params.svh"

package sudokuPkg;

   typedef logic [`SUDOKU_DIM-1:0] cellMask_t;   // bit k set means digit k+1 still possible

   // cell index is row * 9 + col
   typedef cellMask_t [`SUDOKU_CELLS-1:0] grid_t;

   typedef logic [$clog2(`SUDOKU_CELLS+1)-1:0] cellCount_t;

   typedef enum logic [1:0]
   {
      Idle,
      Running,
      Solved,
      Stuck
   } solveState_t;

   typedef struct packed
   {
      solveState_t state;
      cellCount_t  unsolvedCells;
      logic        timeOut;
      logic        allDone;
      logic        anyChanged;
      logic        anyError;
   } solveStatus_t;

   // exactly one candidate left
   function automatic logic isSingle(input cellMask_t m);
      return (m != '0) && ((m & (m - 1'b1)) == '0);
   endfunction

endpackage

// ==== sudokuSolver.sv ====
`timescale 1ns/1ps
`include "sudoku_params.svh"

module sudokuSolver (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    start,
   input  sudokuPkg::grid_t        inGrid,
   output sudokuPkg::grid_t        outGrid,
   output sudokuPkg::solveStatus_t status
);
   import sudokuPkg::*;

   grid_t                    grid;
   logic [`SUDOKU_CELLS-1:0] cellDone;
   logic [`SUDOKU_CELLS-1:0] cellChanged;
   logic [`SUDOKU_CELLS-1:0] cellEmpty;
   logic                     groupConflict;

   cellArray uCellArray (
      .clk         (clk),
      .rst         (rst),
      .start       (start),
      .inGrid      (inGrid),
      .grid        (grid),
      .cellDone    (cellDone),
      .cellChanged (cellChanged),
      .cellEmpty   (cellEmpty)
   );

   groupChecker uGroupChecker (
      .grid          (grid),
      .groupConflict (groupConflict)
   );

   solveMonitor uSolveMonitor (
      .clk           (clk),
      .rst           (rst),
      .start         (start),
      .cellDone      (cellDone),
      .cellChanged   (cellChanged),
      .cellEmpty     (cellEmpty),
      .groupConflict (groupConflict),
      .status        (status)
   );

   assign outGrid = grid;

endmodule

// ==== sudoku_params.svh ====
`ifndef SUDOKU_PARAMS_SVH
`define SUDOKU_PARAMS_SVH

// digits per row, column and box
`define SUDOKU_DIM 9

// side of one box
`define SUDOKU_BOX 3

`define SUDOKU_CELLS (`SUDOKU_DIM * `SUDOKU_DIM)

// cycles without any elimination before timeout
`define SUDOKU_STALL_LIMIT 15

`endif

// ==== tbSudoku.sv ====
`timescale 1ns/1ps
`include "sudoku_params.svh"

module tbSudoku;
   import sudokuPkg::*;

   localparam int NumTests      = 40;
   localparam int CyclesPerTest = 120;   // load, elimination steps and the stall window

   logic         clk;
   logic         rst;
   logic         start;
   grid_t        inGrid;
   grid_t        outGrid;
   solveStatus_t status;
   grid_t        solution;
   logic         dupPlanted;
   int           gridErrors;
   int           statusErrors;
   int           endErrors;
   int           cycleCount = 0;

   // reference model state
   grid_t        mGrid;
   grid_t        stepped;
   cellCount_t   mUnsolved;
   int           mStall;
   logic         mChanged;
   solveState_t  mState;
   solveStatus_t expStatus;

   sudokuSolver u_dut (
      .clk     (clk),
      .rst     (rst),
      .start   (start),
      .inGrid  (inGrid),
      .outGrid (outGrid),
      .status  (status)
   );

   sudokuChecker sudokuChecker (
      .clk          (clk),
      .rst          (rst),
      .start        (start),
      .inGrid       (inGrid),
      .outGrid      (outGrid),
      .status       (status),
      .expGrid      (mGrid),
      .expStatus    (expStatus),
      .solution     (solution),
      .dupPlanted   (dupPlanted),
      .gridErrors   (gridErrors),
      .statusErrors (statusErrors),
      .endErrors    (endErrors)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic isOne(input cellMask_t m);
      return $countones(m) == 1;
   endfunction

   // k-th cell of group gi: rows 0-8, columns 9-17, boxes 18-26
   function automatic int member(input int gi, input int k);
      int j;
      j = gi % 9;
      if (gi < 9)
         return j * 9 + k;
      else if (gi < 18)
         return k * 9 + j;
      return (j / 3 * 3 + k / 3) * 9 + j % 3 * 3 + k % 3;
   endfunction

   // one parallel step: unsolved cells drop every digit solved in their groups
   function automatic grid_t eliminate(input grid_t g);
      grid_t     n;
      cellMask_t taken;
      int        groups [3];
      int        idx;
      n = g;
      for (int i = 0; i < `SUDOKU_CELLS; i++)
      begin
         if (!isOne(g[i]))
         begin
            groups = '{i / 9, 9 + i % 9, 18 + i / 27 * 3 + i % 9 / 3};
            taken  = '0;
            foreach (groups[q])
            begin
               for (int k = 0; k < 9; k++)
               begin
                  idx = member(groups[q], k);
                  if (idx != i && isOne(g[idx]))
                     taken = taken | g[idx];
               end
            end
            n[i] = g[i] & ~taken;
         end
      end
      return n;
   endfunction

   function automatic int openCells(input grid_t g);
      int n;
      n = 0;
      for (int i = 0; i < `SUDOKU_CELLS; i++)
         if (!isOne(g[i]))
            n++;
      return n;
   endfunction

   // empty cell, or one digit solved twice in a group
   function automatic logic inconsistent(input grid_t g);
      int cnt;
      for (int i = 0; i < `SUDOKU_CELLS; i++)
         if (g[i] == '0)
            return 1'b1;
      for (int gi = 0; gi < 27; gi++)
      begin
         for (int d = 0; d < 9; d++)
         begin
            cnt = 0;
            for (int k = 0; k < 9; k++)
               if (g[member(gi, k)] == cellMask_t'(1 << d))
                  cnt++;
            if (cnt > 1)
               return 1'b1;
         end
      end
      return 1'b0;
   endfunction

   always_comb
   begin
      stepped                 = eliminate(mGrid);
      expStatus.state         = mState;
      expStatus.unsolvedCells = mUnsolved;
      expStatus.timeOut       = (mStall == `SUDOKU_STALL_LIMIT);
      expStatus.allDone       = (openCells(mGrid) == 0);
      expStatus.anyChanged    = mChanged;
      expStatus.anyError      = inconsistent(mGrid) && (mState != Idle);
   end

   always @(posedge clk)
   begin
      if (rst)
      begin
         mGrid     <= '0;
         mUnsolved <= cellCount_t'(`SUDOKU_CELLS);
         mStall    <= 0;
         mChanged  <= 1'b0;
         mState    <= Idle;
      end
      else
      begin
         mGrid     <= start ? inGrid : stepped;
         mUnsolved <= start ? cellCount_t'(`SUDOKU_CELLS) : cellCount_t'(openCells(mGrid));
         mChanged  <= (stepped != mGrid);
         if (start || stepped != mGrid)
            mStall <= 0;
         else if (mStall < `SUDOKU_STALL_LIMIT)
            mStall <= mStall + 1;
         if (start)
            mState <= Running;
         else if (mState == Running && expStatus.allDone && !expStatus.anyError)
            mState <= Solved;
         else if (mState == Running && (expStatus.timeOut || expStatus.anyError))
            mState <= Stuck;
      end
   end

   task automatic makePuzzle(input logic plantDup, output grid_t puzzle, output grid_t answer);
      int digit [9];
      int rowMap [9];
      int colMap [9];
      int a;
      int b;
      int t;
      int r;
      int c;
      int blanks;
      for (int i = 0; i < 9; i++)
      begin
         digit[i]  = i;
         rowMap[i] = i;
         colMap[i] = i;
      end
      for (int i = 8; i > 0; i--)   // relabel digits
      begin
         a        = $urandom_range(i, 0);
         t        = digit[i];
         digit[i] = digit[a];
         digit[a] = t;
      end
      for (int i = 0; i < 9; i++)   // swaps stay inside a band or a stack
      begin
         a         = i / 3 * 3 + $urandom_range(2, 0);
         t         = rowMap[i];
         rowMap[i] = rowMap[a];
         rowMap[a] = t;
         b         = i / 3 * 3 + $urandom_range(2, 0);
         t         = colMap[i];
         colMap[i] = colMap[b];
         colMap[b] = t;
      end
      blanks = $urandom_range(60, 20);
      for (int i = 0; i < `SUDOKU_CELLS; i++)
      begin
         r         = rowMap[i / 9];
         c         = colMap[i % 9];
         answer[i] = cellMask_t'(1 << digit[(r * 3 + r / 3 + c) % 9]);
         puzzle[i] = ($urandom_range(80, 0) < blanks) ? '1 : answer[i];
      end
      if (plantDup)
      begin
         r             = $urandom_range(8, 0) * 9;
         a             = $urandom_range(8, 0);
         b             = (a + 1 + $urandom_range(7, 0)) % 9;
         puzzle[r + a] = answer[r + a];
         puzzle[r + b] = answer[r + a];   // same digit twice in one row
      end
   endtask

   task automatic finishRun();
      $display("errors: grid %0d, status %0d, end state %0d",
               gridErrors, statusErrors, endErrors);
      if (gridErrors + statusErrors + endErrors == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   endtask

   always @(posedge clk)
   begin
      cycleCount <= cycleCount + 1;
      if (cycleCount == NumTests * CyclesPerTest)
      begin
         $display("timeout: run did not finish within %0d cycles", cycleCount);
         $display("Regression failed");
         $finish;
      end
   end

   initial
   begin
      grid_t puzzle;
      grid_t answer;
      void'($urandom(32'h5a67_053f));
      rst        = 1'b1;
      start      = 1'b0;
      inGrid     = '0;
      solution   = '0;
      dupPlanted = 1'b0;
      repeat (8) @(posedge clk);
      rst <= 1'b0;
      for (int t = 0; t < NumTests; t++)
      begin
         makePuzzle(t % 5 == 3, puzzle, answer);
         @(posedge clk);
         start  <= 1'b1;
         inGrid <= puzzle;
         @(posedge clk);
         start      <= 1'b0;
         solution   <= answer;   // switches on the load edge of the DUT
         dupPlanted <= (t % 5 == 3);
         do
            @(negedge clk);
         while (status.state != Solved && status.state != Stuck);
      end
      @(posedge clk);
      finishRun();
   end

endmodule
